// File: hw/rvv_retire_pkg.sv
// shared retire types; VLEN fixed at 128 and XLEN at 32, only body_active enables a byte write
package rvv_retire_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int VLEN      = 128;
  localparam int VLENB     = VLEN / 8;
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // vector CSR field widths
  localparam int VSTART_W = 16;
  localparam int VL_W     = 16;

  ////////////////////////////////////////////////////////////////////////////
  // per-byte tag of a destination register
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    body_inactive = 2'b00, // masked off
    tail          = 2'b01,
    prestart      = 2'b10, // below vstart
    body_active   = 2'b11  // the only code that writes
  } byte_type_e;

  // scalar view of a retire word, result sits in the low bits
  typedef struct packed {
    logic [VLEN-XLEN-1:0] pad;
    logic [XLEN-1:0]      xdata;
  } rt_scalar_t;

  // one retire word, read as a vector value or as an XRF result
  typedef union packed {
    logic [VLEN-1:0] vec;
    rt_scalar_t      scalar;
  } rt_data_u;

  ////////////////////////////////////////////////////////////////////////////
  // vector CSR state
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [VSTART_W-1:0] vstart;
    logic [VL_W-1:0]     vl;
    logic                vill;
    logic                vma;   // mask agnostic
    logic                vta;   // tail agnostic
    logic [2:0]          vsew;
    logic [2:0]          vlmul;
    logic [1:0]          vxrm;  // fixed-point rounding mode
  } vcsr_t;

  // one micro-op leaving the reorder buffer
  typedef struct packed {
    logic                           w_valid;
    logic                           w_type;     // 0 vrf, 1 xrf
    logic [REG_IDX_W-1:0]           w_index;
    byte_type_e [VLENB-1:0]         vd_type;
    rt_data_u                       w_data;
    logic                           trap_flag;
    vcsr_t                          vector_csr;
    logic [VLENB-1:0]               vsaturate;  // per byte fixed-point overflow
  } rob2rt_t;

  ////////////////////////////////////////////////////////////////////////////
  // register file write ports
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [REG_IDX_W-1:0] rt_index;
    logic [VLEN-1:0]      rt_data;
    logic [VLENB-1:0]     rt_strobe;
  } rt2vrf_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] rt_index;
    logic [XLEN-1:0]      rt_data;
  } rt2xrf_t;

endpackage

// File: hw/rt_strobe_merge.sv
// byte strobes for VRF writes; only the leading same-destination group is trimmed for WAW
module rt_strobe_merge #(
  parameter int NUM_RT_UOP = 4
) (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic [NUM_RT_UOP-1:0]                                         slot_valid,
  input  logic [NUM_RT_UOP-1:0]                                         w_type,
  input  logic [NUM_RT_UOP-1:0][rvv_retire_pkg::REG_IDX_W-1:0]          w_index,
  input  rvv_retire_pkg::byte_type_e [NUM_RT_UOP-1:0][rvv_retire_pkg::VLENB-1:0] vd_type,
  output logic [NUM_RT_UOP-1:0][rvv_retire_pkg::VLENB-1:0]              strobe
);

  import rvv_retire_pkg::*;

  logic [NUM_RT_UOP-1:0]                       same_dst;  // slot matches its predecessor
  logic [NUM_RT_UOP-1:0]                       in_group;  // leading group, always a prefix
  logic [NUM_RT_UOP-1:0][VLENB-1:0]            byte_en;   // untrimmed strobes
  logic [NUM_RT_UOP-1:0][NUM_RT_UOP-1:0][VLENB-1:0] claim; // bytes slot t takes from slot s
  logic [NUM_RT_UOP-1:0][VLENB-1:0]            claimed;

  ////////////////////////////////////////////////////////////////////////////
  // group detection
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    same_dst[0] = 1'b1; // slot 0 opens the group
    for (int k = 1; k < NUM_RT_UOP; k++) begin
      same_dst[k] = ({slot_valid[k], w_type[k]} == {slot_valid[k-1], w_type[k-1]});
    end
  end

  always_comb begin
    in_group[0] = same_dst[0];
    for (int k = 1; k < NUM_RT_UOP; k++) begin
      in_group[k] = in_group[k-1] & same_dst[k]; // first break ends it
    end
  end

  // body-active bytes
  always_comb begin
    for (int s = 0; s < NUM_RT_UOP; s++) begin
      for (int i = 0; i < VLENB; i++) begin
        byte_en[s][i] = (vd_type[s][i] == body_active);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write-after-write trim over slot pairs
  ////////////////////////////////////////////////////////////////////////////
  // a younger group slot with the same index owns every byte it writes,
  // so each byte of a register ends up one-hot across the group
  for (genvar s = 0; s < NUM_RT_UOP; s++) begin : g_older
    for (genvar t = 0; t < NUM_RT_UOP; t++) begin : g_younger
      if (t > s) begin : g_pair
        // in_group[t] implies in_group[s] since the group is a prefix
        assign claim[s][t] = (in_group[t] && (w_index[t] == w_index[s])) ?
                             byte_en[t] : '0;

        // trimmed strobes of one register never overlap inside the group
        a_waw_onehot: assert property (
          @(posedge clk) disable iff (!rst_n)
          (in_group[t] && (w_index[s] == w_index[t])) |->
            ((strobe[s] & strobe[t]) == '0)
        );
      end else begin : g_none
        assign claim[s][t] = '0;
      end
    end
  end

  always_comb begin
    for (int s = 0; s < NUM_RT_UOP; s++) begin
      claimed[s] = '0;
      for (int t = 0; t < NUM_RT_UOP; t++) begin
        claimed[s] = claimed[s] | claim[s][t];
      end
    end
  end

  // slots outside the group keep byte_en since nothing claims from them
  always_comb begin
    for (int s = 0; s < NUM_RT_UOP; s++) begin
      strobe[s] = byte_en[s] & ~claimed[s];
    end
  end

endmodule

// File: hw/rt_trap_ctrl.sv
// trap squash and write routing; a trap squashes all younger slots, vxsat can only be set here
module rt_trap_ctrl #(
  parameter int NUM_RT_UOP = 4
) (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic [NUM_RT_UOP-1:0]                                         w_valid,
  input  logic [NUM_RT_UOP-1:0]                                         w_type,
  input  logic [NUM_RT_UOP-1:0]                                         trap_flag,
  input  rvv_retire_pkg::vcsr_t [NUM_RT_UOP-1:0]                        vector_csr,
  input  logic [NUM_RT_UOP-1:0][rvv_retire_pkg::VLENB-1:0]              vsaturate,
  input  rvv_retire_pkg::byte_type_e [NUM_RT_UOP-1:0][rvv_retire_pkg::VLENB-1:0] vd_type,
  input  logic [NUM_RT_UOP-1:0]                                         xrf_ready,
  output logic [NUM_RT_UOP-1:0]                                         vrf_valid,
  output logic [NUM_RT_UOP-1:0]                                         xrf_valid,
  output logic [NUM_RT_UOP-1:0]                                         ready,
  output logic                                                          vcsr_valid,
  output rvv_retire_pkg::vcsr_t                                         vcsr_data,
  output logic                                                          vsat_valid,
  output logic                                                          vsat_data
);

  import rvv_retire_pkg::*;

  logic [NUM_RT_UOP-1:0] older_trap;  // some older slot traps
  logic [NUM_RT_UOP-1:0] live;        // valid and not squashed
  logic [NUM_RT_UOP-1:0] csr_hit;
  logic [NUM_RT_UOP-1:0] slot_sat;

  ////////////////////////////////////////////////////////////////////////////
  // squash and routing
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    older_trap[0] = 1'b0;
    for (int k = 1; k < NUM_RT_UOP; k++) begin
      older_trap[k] = older_trap[k-1] | trap_flag[k-1]; // prefix or
    end
  end

  assign live      = w_valid & ~older_trap;
  assign vrf_valid = live & ~w_type;
  assign xrf_valid = live & w_type;

  // oldest valid trapping slot writes the CSR state
  assign csr_hit    = w_valid & trap_flag;
  assign vcsr_valid = |csr_hit;

  always_comb begin
    vcsr_data = '0;
    for (int k = NUM_RT_UOP - 1; k >= 0; k--) begin
      if (csr_hit[k]) begin
        vcsr_data = vector_csr[k]; // lower slot overrides
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fixed-point saturation
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < NUM_RT_UOP; k++) begin
      slot_sat[k] = 1'b0;
      for (int i = 0; i < VLENB; i++) begin
        slot_sat[k] = slot_sat[k] | (vsaturate[k][i] & (vd_type[k][i] == body_active));
      end
    end
  end

  assign vsat_valid = |(live & slot_sat);
  assign vsat_data  = vsat_valid; // sticky bit, only ever set

  // xrf back-pressure, vrf always accepts
  always_comb begin
    for (int k = 0; k < NUM_RT_UOP; k++) begin
      ready[k] = xrf_valid[k] ? xrf_ready[k] : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  a_one_dest: assert property (
    @(posedge clk) disable iff (!rst_n)
    (vrf_valid & xrf_valid) == '0
  );

  for (genvar k = 0; k < NUM_RT_UOP - 1; k++) begin : g_squash_chk
    localparam logic [NUM_RT_UOP-1:0] YOUNGER = {NUM_RT_UOP{1'b1}} << (k + 1);

    a_no_valid_after_trap: assert property (
      @(posedge clk) disable iff (!rst_n)
      trap_flag[k] |-> (((vrf_valid | xrf_valid) & YOUNGER) == '0)
    );
  end

endmodule

// File: hw/rvv_retire.sv
// retire stage top; purely combinational, clk and rst_n only drive the assertions
module rvv_retire #(
  parameter int NUM_RT_UOP = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // reorder buffer
  input  logic [NUM_RT_UOP-1:0]                     rob2rt_write_valid,
  input  rvv_retire_pkg::rob2rt_t [NUM_RT_UOP-1:0]  rob2rt_write_data,
  output logic [NUM_RT_UOP-1:0]                     rob2rt_write_ready,
  // vrf, no back-pressure
  output logic [NUM_RT_UOP-1:0]                     rt2vrf_write_valid,
  output rvv_retire_pkg::rt2vrf_t [NUM_RT_UOP-1:0]  rt2vrf_write_data,
  // xrf
  output logic [NUM_RT_UOP-1:0]                     rt2xrf_write_valid,
  output rvv_retire_pkg::rt2xrf_t [NUM_RT_UOP-1:0]  rt2xrf_write_data,
  input  logic [NUM_RT_UOP-1:0]                     rt2xrf_write_ready,
  // csr side
  output logic                                      rt2vcsr_write_valid,
  output rvv_retire_pkg::vcsr_t                     rt2vcsr_write_data,
  output logic                                      rt2vsat_write_valid,
  output logic                                      rt2vsat_write_data
);

  import rvv_retire_pkg::*;

  logic [NUM_RT_UOP-1:0]                  ent_valid;   // entry's own w_valid
  logic [NUM_RT_UOP-1:0]                  ent_type;
  logic [NUM_RT_UOP-1:0]                  ent_trap;
  logic [NUM_RT_UOP-1:0][REG_IDX_W-1:0]   ent_index;
  byte_type_e [NUM_RT_UOP-1:0][VLENB-1:0] ent_vd_type;
  vcsr_t [NUM_RT_UOP-1:0]                 ent_vcsr;
  logic [NUM_RT_UOP-1:0][VLENB-1:0]       ent_vsat;
  logic [NUM_RT_UOP-1:0][VLENB-1:0]       vrf_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // unpack reorder buffer entries
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < NUM_RT_UOP; k++) begin
      ent_valid[k]   = rob2rt_write_data[k].w_valid;
      ent_type[k]    = rob2rt_write_data[k].w_type;
      ent_trap[k]    = rob2rt_write_data[k].trap_flag;
      ent_index[k]   = rob2rt_write_data[k].w_index;
      ent_vd_type[k] = rob2rt_write_data[k].vd_type;
      ent_vcsr[k]    = rob2rt_write_data[k].vector_csr;
      ent_vsat[k]    = rob2rt_write_data[k].vsaturate;
    end
  end

  // grouping uses the port valid, as the rob presents it
  rt_strobe_merge #(
    .NUM_RT_UOP (NUM_RT_UOP)
  ) u_strobe_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .slot_valid (rob2rt_write_valid),
    .w_type     (ent_type),
    .w_index    (ent_index),
    .vd_type    (ent_vd_type),
    .strobe     (vrf_strobe)
  );

  rt_trap_ctrl #(
    .NUM_RT_UOP (NUM_RT_UOP)
  ) u_trap_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .w_valid    (ent_valid),
    .w_type     (ent_type),
    .trap_flag  (ent_trap),
    .vector_csr (ent_vcsr),
    .vsaturate  (ent_vsat),
    .vd_type    (ent_vd_type),
    .xrf_ready  (rt2xrf_write_ready),
    .vrf_valid  (rt2vrf_write_valid),
    .xrf_valid  (rt2xrf_write_valid),
    .ready      (rob2rt_write_ready),
    .vcsr_valid (rt2vcsr_write_valid),
    .vcsr_data  (rt2vcsr_write_data),
    .vsat_valid (rt2vsat_write_valid),
    .vsat_data  (rt2vsat_write_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pack write ports
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < NUM_RT_UOP; k++) begin
      rt2vrf_write_data[k].rt_index  = ent_index[k];
      rt2vrf_write_data[k].rt_data   = rob2rt_write_data[k].w_data.vec;
      rt2vrf_write_data[k].rt_strobe = vrf_strobe[k];
      rt2xrf_write_data[k].rt_index  = ent_index[k];
      rt2xrf_write_data[k].rt_data   = rob2rt_write_data[k].w_data.scalar.xdata; // low XLEN bits
    end
  end

endmodule

// File: bench/tb_ref_model.svh
// expected retire outputs from the stage rules; needs NSLOT and the retire package types in scope
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// valid entries not behind a trapping slot
function automatic logic [NSLOT-1:0] exp_live(input rob2rt_t [NSLOT-1:0] e);
  logic [NSLOT-1:0] live;
  logic             trapped;
  trapped = 1'b0;
  for (int k = 0; k < NSLOT; k++) begin
    live[k] = e[k].w_valid & ~trapped;
    trapped = trapped | e[k].trap_flag; // trap flag alone squashes younger slots
  end
  return live;
endfunction

function automatic logic [NSLOT-1:0] exp_vrf_valid(input rob2rt_t [NSLOT-1:0] e);
  logic [NSLOT-1:0] v;
  v = exp_live(e);
  for (int k = 0; k < NSLOT; k++) begin
    v[k] = v[k] & ~e[k].w_type;
  end
  return v;
endfunction

function automatic logic [NSLOT-1:0] exp_xrf_valid(input rob2rt_t [NSLOT-1:0] e);
  logic [NSLOT-1:0] v;
  v = exp_live(e);
  for (int k = 0; k < NSLOT; k++) begin
    v[k] = v[k] & e[k].w_type;
  end
  return v;
endfunction

// body-active bytes, younger same-index slot of the leading group wins
function automatic logic [NSLOT-1:0][VLENB-1:0] exp_strobe(input logic [NSLOT-1:0] pv,
                                                          input rob2rt_t [NSLOT-1:0] e);
  logic [NSLOT-1:0][VLENB-1:0] st;
  int                          glen;
  glen = 1;
  for (int k = 1; k < NSLOT; k++) begin
    if (glen == k && pv[k] == pv[k-1] && e[k].w_type == e[k-1].w_type) glen = k + 1;
  end
  for (int s = 0; s < NSLOT; s++) begin
    for (int i = 0; i < VLENB; i++) begin
      st[s][i] = (e[s].vd_type[i] == body_active);
    end
  end
  for (int s = 0; s < glen; s++) begin
    for (int t = s + 1; t < glen; t++) begin
      for (int i = 0; i < VLENB; i++) begin
        if (e[t].w_index == e[s].w_index && e[t].vd_type[i] == body_active) st[s][i] = 1'b0;
      end
    end
  end
  return st;
endfunction

function automatic logic exp_csr_valid(input rob2rt_t [NSLOT-1:0] e);
  for (int k = 0; k < NSLOT; k++) begin
    if (e[k].w_valid && e[k].trap_flag) return 1'b1;
  end
  return 1'b0;
endfunction

// oldest valid trapping slot
function automatic vcsr_t exp_csr_data(input rob2rt_t [NSLOT-1:0] e);
  for (int k = 0; k < NSLOT; k++) begin
    if (e[k].w_valid && e[k].trap_flag) return e[k].vector_csr;
  end
  return '0;
endfunction

function automatic logic exp_vsat(input rob2rt_t [NSLOT-1:0] e);
  logic [NSLOT-1:0] live;
  live = exp_live(e);
  for (int k = 0; k < NSLOT; k++) begin
    for (int i = 0; i < VLENB; i++) begin
      if (live[k] && e[k].vsaturate[i] && e[k].vd_type[i] == body_active) return 1'b1;
    end
  end
  return 1'b0;
endfunction

// only an xrf write can be held off
function automatic logic [NSLOT-1:0] exp_ready(input rob2rt_t [NSLOT-1:0] e,
                                              input logic [NSLOT-1:0] xr);
  return ~exp_xrf_valid(e) | xr;
endfunction

`endif

// File: bench/tb_rvv_retire.sv
// four-slot retire testbench; inputs change on the rising edge, outputs are checked on the falling edge
module tb_rvv_retire;

  import rvv_retire_pkg::*;

  localparam int NSLOT        = 4;
  localparam int STEP_TIMEOUT = 8;
  // slot indices {s3, s2, s1, s0}; the last one also breaks the group at slot 2
  localparam logic [19:0] WAW_PAT [5] = '{
    {5'd3, 5'd3, 5'd3, 5'd3}, {5'd2, 5'd2, 5'd1, 5'd1}, {5'd5, 5'd6, 5'd5, 5'd5},
    {5'd9, 5'd4, 5'd9, 5'd4}, {5'd7, 5'd7, 5'd7, 5'd7}
  };

  `include "tb_ref_model.svh"

  logic                    clk;
  logic                    rst_n;
  logic [NSLOT-1:0]        rob_valid;
  rob2rt_t [NSLOT-1:0]     rob_data;
  logic [NSLOT-1:0]        rob_ready;
  logic [NSLOT-1:0]        vrf_valid;
  rt2vrf_t [NSLOT-1:0]     vrf_data;
  logic [NSLOT-1:0]        xrf_valid;
  rt2xrf_t [NSLOT-1:0]     xrf_data;
  logic [NSLOT-1:0]        xrf_ready;
  logic                    vcsr_valid;
  vcsr_t                   vcsr_data;
  logic                    vsat_valid;
  logic                    vsat_data;

  logic [NSLOT-1:0]        next_valid;
  rob2rt_t [NSLOT-1:0]     next_data;
  logic [NSLOT-1:0]        next_ready;
  string                   test_name = "reset";
  int                      seed      = 58064;
  int                      n_err     = 0;
  int                      n_timeout = 0;
  int                      n_checked = 0;

  rvv_retire #(
    .NUM_RT_UOP (NSLOT)
  ) dut0 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .rob2rt_write_valid  (rob_valid),
    .rob2rt_write_data   (rob_data),
    .rob2rt_write_ready  (rob_ready),
    .rt2vrf_write_valid  (vrf_valid),
    .rt2vrf_write_data   (vrf_data),
    .rt2xrf_write_valid  (xrf_valid),
    .rt2xrf_write_data   (xrf_data),
    .rt2xrf_write_ready  (xrf_ready),
    .rt2vcsr_write_valid (vcsr_valid),
    .rt2vcsr_write_data  (vcsr_data),
    .rt2vsat_write_valid (vsat_valid),
    .rt2vsat_write_data  (vsat_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic rand_entry(output rob2rt_t e);
    logic [31:0] r;
    logic [63:0] w;
    r = $random(seed);
    e.w_valid   = r[0];
    e.w_type    = r[1];
    e.w_index   = r[6:2];
    e.trap_flag = 1'b0;
    r = $random(seed);
    for (int i = 0; i < VLENB; i++) e.vd_type[i] = byte_type_e'(r[2*i +: 2]);
    e.w_data.vec = {$random(seed), $random(seed), $random(seed), $random(seed)};
    w = {$random(seed), $random(seed)};
    e.vector_csr = w[$bits(vcsr_t)-1:0];
    r = $random(seed);
    e.vsaturate = r[VLENB-1:0];
  endtask

  task automatic fill_random(input bit traps);
    logic [31:0] r;
    for (int k = 0; k < NSLOT; k++) begin
      rand_entry(next_data[k]);
      r = $random(seed);
      next_data[k].trap_flag = traps & (r[1:0] == 2'b00); // about one slot in four
      next_valid[k] = next_data[k].w_valid;
    end
  endtask

  // drive one cycle, then wait until the compare process has seen it
  task automatic step(input string name);
    int start;
    int waited;
    if (n_timeout == 0) begin
      start     = n_checked;
      waited    = 0;
      test_name = name;
      rob_valid <= next_valid;
      rob_data  <= next_data;
      xrf_ready <= next_ready;
      while (n_checked == start && waited < STEP_TIMEOUT) begin
        @(posedge clk);
        waited++;
      end
      if (n_checked == start) begin
        $display("timeout: outputs of %s were not checked within %0d cycles", name, waited);
        n_timeout++;
      end
    end
  endtask

  task automatic check_val(input string what, input logic [159:0] exp, input logic [159:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      n_err++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  initial begin : compare
    logic [NSLOT-1:0][VLENB-1:0] st;
    logic [VLEN-1:0]             wd;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        st = exp_strobe(rob_valid, rob_data);
        check_val("ready", 160'(exp_ready(rob_data, xrf_ready)), 160'(rob_ready));
        check_val("vrf_valid", 160'(exp_vrf_valid(rob_data)), 160'(vrf_valid));
        check_val("xrf_valid", 160'(exp_xrf_valid(rob_data)), 160'(xrf_valid));
        for (int k = 0; k < NSLOT; k++) begin
          wd = rob_data[k].w_data;
          check_val($sformatf("vrf_data[%0d]", k),
                    160'({rob_data[k].w_index, wd, st[k]}), 160'(vrf_data[k]));
          check_val($sformatf("xrf_data[%0d]", k),
                    160'({rob_data[k].w_index, wd[XLEN-1:0]}), 160'(xrf_data[k]));
        end
        check_val("vcsr_valid", 160'(exp_csr_valid(rob_data)), 160'(vcsr_valid));
        if (exp_csr_valid(rob_data)) begin
          check_val("vcsr_data", 160'(exp_csr_data(rob_data)), 160'(vcsr_data));
        end
        check_val("vsat_valid", 160'(exp_vsat(rob_data)), 160'(vsat_valid));
        if (exp_vsat(rob_data)) check_val("vsat_data", 160'(1'b1), 160'(vsat_data));
        n_checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n      = 1'b0;
    rob_valid  = '0;
    rob_data   = '0;
    xrf_ready  = '1;
    next_valid = '0;
    next_data  = '0;
    next_ready = '1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    step("idle");

    for (int r = 0; r < 40; r++) begin
      fill_random(1'b0);
      step("routing");
    end

    for (int r = 0; r < 30; r++) begin
      fill_random(1'b0);
      for (int k = 0; k < NSLOT; k++) begin
        next_data[k].w_valid = 1'b1;
        next_data[k].w_type  = 1'b0;
        next_data[k].w_index = 5'(4 * r + k); // distinct within a cycle
        next_valid[k]        = 1'b1;
      end
      step("strobe");
    end

    for (int p = 0; p < 5; p++) begin
      for (int r = 0; r < 8; r++) begin
        fill_random(1'b0);
        for (int k = 0; k < NSLOT; k++) begin
          next_data[k].w_valid = 1'b1;
          next_data[k].w_type  = (p == 4 && k == 2);
          next_data[k].w_index = WAW_PAT[p][5*k +: 5];
          next_valid[k]        = 1'b1;
        end
        step($sformatf("waw_%0d", p));
      end
    end

    for (int pos = 0; pos < NSLOT; pos++) begin
      for (int r = 0; r < 6; r++) begin
        fill_random(1'b0);
        next_valid = '1;
        for (int k = 0; k < NSLOT; k++) next_data[k].w_valid = 1'b1;
        next_data[pos].trap_flag = 1'b1;
        if (r[0] && pos < NSLOT - 1) next_data[pos+1].trap_flag = 1'b1; // younger trap too
        if (r == 5) next_data[pos].w_valid = 1'b0; // trap without a write
        step($sformatf("trap_%0d", pos));
      end
    end

    for (int r = 0; r < 40; r++) begin
      fill_random(1'b1);
      step("saturation");
    end

    for (int r = 0; r < 30; r++) begin
      logic [31:0] rr;
      if (r % 5 == 0) fill_random(1'b0); // rob holds the slots while stalled
      rr = $random(seed);
      next_ready = rr[NSLOT-1:0];
      step("backpressure");
    end

    $display("errors: %0d mismatches, %0d timeouts", n_err, n_timeout);
    if (n_err == 0 && n_timeout == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
hw/rvv_retire_pkg.sv
hw/rt_strobe_merge.sv
hw/rt_trap_ctrl.sv
hw/rvv_retire.sv
+incdir+bench
bench/tb_rvv_retire.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rvv_retire
FLIST     ?= list.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
